/* proc_config.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Storage depths for the processor
// Memories are word arrays indexed by byte address bits above bit 0
// Depths must be powers of two
// ~~~~~~~~~~~~~~~~~~~~
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Instruction memory, in 16-bit words
`define PROC_IMEM_WORDS 256

// Data memory, in 16-bit words
`define PROC_DMEM_WORDS 256

// Register file, must match the 3-bit register fields
`define PROC_NUM_REGS 8

`endif

/* isaPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction set of the reduced 16-bit core
// Opcodes not listed in opcodeT are illegal
// ~~~~~~~~~~~~~~~~~~~~
package isaPkg;

   // Opcode field, bits 15..11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opJ     = 5'b00100,  // PC+2 + simm11
      opJr    = 5'b00101,  // Rs + simm8
      opJal   = 5'b00110,  // Links PC+2 into r7
      opAddi  = 5'b01000,
      opAndni = 5'b01011,  // Rs & ~zimm5
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,  // mem[Rs + simm5] = Rt field
      opLd    = 5'b10001,
      opLbi   = 5'b11000,  // Rs = simm8
      opAlu   = 5'b11011   // R-format, op in funct
   } opcodeT;

   // R-format operation, bits 1..0
   typedef enum logic [1:0] {
      fnAdd = 2'b00,
      fnSub = 2'b01,  // Rs minus Rt
      fnXor = 2'b10,
      fnAnd = 2'b11
   } functT;

   // Field view of one instruction word
   // Immediates overlay the low bits, so blocks slice the packed word for them
   typedef struct packed {
      opcodeT      opcode;  // 15..11
      logic [2:0]  rs;      // 10..8
      logic [2:0]  rt;      // 7..5, also I-format destination
      logic [2:0]  rd;      // 4..2, R-format destination
      functT       funct;   // 1..0
   } instrT;

endpackage

/* ctrlPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Control word and trace types
// One ctrlT per instruction, all fields are plain levels
// ~~~~~~~~~~~~~~~~~~~~
package ctrlPkg;

   typedef enum logic [2:0] {
      aluAdd, aluSub, aluAnd, aluAndn, aluXor, aluPassA
   } aluOpT;

   typedef enum logic [1:0] {
      immS5, immZ5, immS8, immS11  // s = sign extend, z = zero extend
   } immSelT;

   typedef enum logic [1:0] {
      wbAlu, wbMem, wbPc2
   } wbSrcT;

   typedef enum logic [1:0] {
      dstRd, dstRt, dstRs, dstR7
   } destSelT;

   typedef enum logic [1:0] {
      pcSelNext, pcSelBranch, pcSelJmpRel, pcSelJmpReg
   } pcSelT;

   typedef struct packed {
      logic    regWrite;
      destSelT destSel;
      immSelT  immSel;
      logic    useImm;    // ALU B is immExt, else Rt
      aluOpT   aluOp;
      logic    memEn;
      logic    memWr;
      wbSrcT   wbSrc;
      pcSelT   pcSel;     // Branch only when taken
   } ctrlT;

   // Register write seen by the outside world
   typedef struct packed {
      logic        wrEn;
      logic [2:0]  wrReg;
      logic [15:0] wrData;
   } traceT;

endpackage

/* fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// PC and instruction memory
// Loader writes are taken only while rst is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module fetch import isaPkg::*, ctrlPkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  logic         progWr,
   input  logic [15:0]  progAddr,
   input  logic [15:0]  progData,
   input  ctrlT         ctrl,
   input  logic         halted,
   input  logic [15:0]  rsVal,
   input  logic [15:0]  immExt,
   output instrT        instr,
   output logic [15:0]  pcNext
);

   localparam int IW = $clog2(`PROC_IMEM_WORDS);

   logic [15:0] imem [`PROC_IMEM_WORDS];
   logic [15:0] pc;
   logic [15:0] pcTarget;

   // Program load port, no reset on the array
   always_ff @(posedge clk) begin
      if (rst && progWr) imem[progAddr[IW:1]] <= progData;
   end

   assign instr  = instrT'(imem[pc[IW:1]]);  // Word read, bit 0 ignored
   assign pcNext = pc + 16'd2;

   always_comb begin
      case (ctrl.pcSel)
         pcSelBranch, pcSelJmpRel: pcTarget = pcNext + immExt;  // PC-relative
         pcSelJmpReg:              pcTarget = rsVal + immExt;   // JR
         default:                  pcTarget = pcNext;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) pc <= '0;
      else if (!halted) pc <= pcTarget;  // Frozen once halted
   end

endmodule
`default_nettype wire

/* decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Register file, immediate extension and write-back select
// Eight registers, r0 is writable like any other
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module decode import isaPkg::*, ctrlPkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  instrT        instr,
   input  ctrlT         ctrl,
   input  logic [15:0]  aluOut,
   input  logic [15:0]  memOut,
   input  logic [15:0]  pcNext,
   output logic [15:0]  rsVal,
   output logic [15:0]  rtVal,
   output logic [15:0]  immExt,
   output traceT        trace
);

   logic [15:0] regs [`PROC_NUM_REGS];
   logic [2:0]  wrReg;
   logic [15:0] wrData;

   // Two async read ports; ST data sits in the Rt field
   assign rsVal = regs[instr.rs];
   assign rtVal = regs[instr.rt];

   always_comb begin
      case (ctrl.immSel)
         immS5:   immExt = {{11{instr[4]}}, instr[4:0]};
         immZ5:   immExt = {11'b0, instr[4:0]};       // ANDNI
         immS8:   immExt = {{8{instr[7]}}, instr[7:0]};  // LBI, branches, JR
         default: immExt = {{5{instr[10]}}, instr[10:0]};  // J, JAL
      endcase
   end

   always_comb begin
      case (ctrl.destSel)
         dstRd:   wrReg = instr.rd;
         dstRt:   wrReg = instr.rt;  // I-format dest
         dstRs:   wrReg = instr.rs;  // LBI
         default: wrReg = 3'd7;      // JAL link
      endcase
   end

   // Write-back source
   always_comb begin
      case (ctrl.wbSrc)
         wbMem:   wrData = memOut;
         wbPc2:   wrData = pcNext;
         default: wrData = aluOut;
      endcase
   end

   assign trace = '{wrEn: ctrl.regWrite, wrReg: wrReg, wrData: wrData};

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) regs[i] <= '0;
      end else if (ctrl.regWrite) begin
         regs[wrReg] <= wrData;
      end
   end

endmodule
`default_nettype wire

/* execute.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Combinational ALU with zero and sign flags
// No shifts, no carry out
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module execute import isaPkg::*, ctrlPkg::*; (
   input  instrT        instr,
   input  ctrlT         ctrl,
   input  logic [15:0]  rsVal,
   input  logic [15:0]  rtVal,
   input  logic [15:0]  immExt,
   output logic [15:0]  aluOut,
   output logic         zero,
   output logic         sign
);

   logic [15:0] opA;
   logic [15:0] opB;

   // LBI names its dest in Rs, so A is forced to zero and ADD passes the imm
   assign opA = (instr.opcode == opLbi) ? 16'd0 : rsVal;
   assign opB = ctrl.useImm ? immExt : rtVal;

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  aluOut = opA + opB;  // Also ST/LD address
         aluSub:  aluOut = opA - opB;
         aluAnd:  aluOut = opA & opB;
         aluAndn: aluOut = opA & ~opB;
         aluXor:  aluOut = opA ^ opB;
         default: aluOut = opA;        // PASSA, Rs for the branch test
      endcase
   end

   // Flags feed branch resolution in control
   assign zero = (aluOut == 16'd0);
   assign sign = aluOut[15];

endmodule
`default_nettype wire

/* memory.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Word-wide data memory, async read, sync write
// No reset, contents undefined until written
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module memory import ctrlPkg::*; (
   input  wire          clk,
   input  ctrlT         ctrl,
   input  logic [15:0]  addr,
   input  logic [15:0]  wrData,
   output logic [15:0]  rdData
);

   localparam int DW = $clog2(`PROC_DMEM_WORDS);

   logic [15:0] dmem [`PROC_DMEM_WORDS];

   always_ff @(posedge clk) begin
      if (ctrl.memEn && ctrl.memWr) dmem[addr[DW:1]] <= wrData;  // ST
   end

   // Reads zero when not enabled
   assign rdData = ctrl.memEn ? dmem[addr[DW:1]] : 16'd0;

endmodule
`default_nettype wire

/* control.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Opcode decode, branch resolution, halt/err state
// halt and err are sticky until rst
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module control import isaPkg::*, ctrlPkg::*; (
   input  wire    clk,
   input  wire    rst,
   input  instrT  instr,
   input  logic   zero,
   input  logic   sign,
   output ctrlT   ctrl,
   output logic   halted,
   output logic   halt,
   output logic   err
);

   logic haltedQ;
   logic errQ;
   logic brCond;
   logic isHalt;
   logic illegal;

   // Opcode bit 11 splits BEQZ from BNEZ
   assign brCond = instr[11] ? !zero : zero;

   always_comb begin
      ctrl    = '0;
      isHalt  = 1'b0;
      illegal = 1'b0;
      case (instr.opcode)
         opAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstRd;
            case (instr.funct)
               fnAdd:   ctrl.aluOp = aluAdd;
               fnSub:   ctrl.aluOp = aluSub;
               fnXor:   ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAnd;
            endcase
         end
         opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstRt;
            ctrl.useImm   = 1'b1;
         end
         opAndni: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstRt;
            ctrl.immSel   = immZ5;
            ctrl.useImm   = 1'b1;
            ctrl.aluOp    = aluAndn;
         end
         opSt: begin  // Address Rs + simm5
            ctrl.useImm = 1'b1;
            ctrl.memEn  = 1'b1;
            ctrl.memWr  = 1'b1;
         end
         opLd: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstRt;
            ctrl.useImm   = 1'b1;
            ctrl.memEn    = 1'b1;
            ctrl.wbSrc    = wbMem;
         end
         opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstRs;
            ctrl.immSel   = immS8;
            ctrl.useImm   = 1'b1;  // 0 + simm8 in execute
         end
         opBeqz, opBnez: begin
            ctrl.immSel = immS8;
            ctrl.aluOp  = aluPassA;
            ctrl.pcSel  = brCond ? pcSelBranch : pcSelNext;
         end
         opJ: begin
            ctrl.immSel = immS11;
            ctrl.pcSel  = pcSelJmpRel;
         end
         opJal: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = dstR7;
            ctrl.immSel   = immS11;
            ctrl.wbSrc    = wbPc2;
            ctrl.pcSel    = pcSelJmpRel;
         end
         opJr: begin
            ctrl.immSel = immS8;
            ctrl.pcSel  = pcSelJmpReg;
         end
         opHalt:  isHalt = 1'b1;
         default: illegal = 1'b1;  // Word stays all zero, no side effects
      endcase
      if (haltedQ) begin  // No state changes once stopped
         ctrl.regWrite = 1'b0;
         ctrl.memWr    = 1'b0;
      end
   end

   // Guarded by !haltedQ so garbage past HALT cannot raise err
   always_ff @(posedge clk) begin
      if (rst) begin
         haltedQ <= 1'b0;
         errQ    <= 1'b0;
      end else if (!haltedQ && (isHalt || illegal)) begin
         haltedQ <= 1'b1;
         errQ    <= illegal;
      end
   end

   assign halted = haltedQ;  // To fetch, freezes PC
   assign halt   = haltedQ;
   assign err    = errQ;

endmodule
`default_nettype wire

/* proc.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Single-cycle 16-bit core, one instruction per clock
// Load the program through progWr/progAddr/progData while rst is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module proc import isaPkg::*, ctrlPkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  logic         progWr,
   input  logic [15:0]  progAddr,
   input  logic [15:0]  progData,
   output traceT        trace,   // Write-back, valid on wrEn
   output logic         halt,
   output logic         err
);

   instrT       instr;
   ctrlT        ctrl;
   logic        halted;
   logic [15:0] pcNext;
   logic [15:0] rsVal, rtVal, immExt;
   logic [15:0] aluOut, memOut;
   logic        zero, sign;

   fetch F (
      .clk(clk), .rst(rst),
      .progWr(progWr), .progAddr(progAddr), .progData(progData),
      .ctrl(ctrl), .halted(halted), .rsVal(rsVal), .immExt(immExt),
      .instr(instr), .pcNext(pcNext)
   );

   decode D (
      .clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl),
      .aluOut(aluOut), .memOut(memOut), .pcNext(pcNext),
      .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt), .trace(trace)
   );

   execute X (
      .instr(instr), .ctrl(ctrl), .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt),
      .aluOut(aluOut), .zero(zero), .sign(sign)
   );

   // Address from ALU, store data from Rt port
   memory M (
      .clk(clk), .ctrl(ctrl), .addr(aluOut), .wrData(rtVal), .rdData(memOut)
   );

   control CNTRL (
      .clk(clk), .rst(rst), .instr(instr), .zero(zero), .sign(sign),
      .ctrl(ctrl), .halted(halted), .halt(halt), .err(err)
   );

endmodule
`default_nettype wire

/* procTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Runs two programs through proc and checks every write-back
// Outputs are sampled at the falling edge, inputs driven at the rising edge
// Stops at the first mismatch, watchdog bounds the run
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "proc_config.svh"

module procTb import isaPkg::*, ctrlPkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 10;
   localparam int P1_LEN = 24;  // Program 1 words
   localparam int P2_LEN = 5;   // Program 2 words, illegal opcode
   localparam int E1_LEN = 15;  // Expected writes, program 1
   localparam int E2_LEN = 2;
   localparam int WATCH_CYCLES = (P1_LEN + P2_LEN + E1_LEN + E2_LEN) * 20;

   logic        clk;
   logic        rst;
   logic        progWr;
   logic [15:0] progAddr;
   logic [15:0] progData;
   traceT       trace;
   logic        halt;
   logic        err;

   instrT progTab [P1_LEN + P2_LEN];  // Both programs back to back
   traceT expTab [E1_LEN + E2_LEN];   // Expected writes, same order

   proc u_dut (
      .clk(clk), .rst(rst),
      .progWr(progWr), .progAddr(progAddr), .progData(progData),
      .trace(trace), .halt(halt), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Instruction builders, field layout per the ISA
   function automatic instrT rInstr(functT fn, logic [2:0] s, logic [2:0] t, logic [2:0] d);
      rInstr = '{opcode: opAlu, rs: s, rt: t, rd: d, funct: fn};
   endfunction

   function automatic instrT iInstr(opcodeT op, logic [2:0] s, logic [2:0] t, logic [4:0] imm);
      iInstr = instrT'({op, s, t, imm});  // Dest or store data in Rt
   endfunction

   function automatic instrT wideInstr(opcodeT op, logic [2:0] s, logic [7:0] imm);
      wideInstr = instrT'({op, s, imm});  // LBI, branches, JR
   endfunction

   function automatic instrT jumpInstr(opcodeT op, logic [10:0] imm);
      jumpInstr = instrT'({op, imm});
   endfunction

   function automatic traceT expWrite(logic [2:0] r, logic [15:0] d);
      expWrite = '{wrEn: 1'b1, wrReg: r, wrData: d};
   endfunction

   task automatic reportFail(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic checkTrace(input traceT got, input traceT exp, input int entry);
      if (got !== exp)
         reportFail($sformatf("ERR trace[%0d] wrEn/wrReg/wrData got %h/%h/%h exp %h/%h/%h",
                              entry, got.wrEn, got.wrReg, got.wrData,
                              exp.wrEn, exp.wrReg, exp.wrData));
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
         reportFail($sformatf("ERR %s got %h exp %h", name, got, exp));
   endtask

   task automatic fillTables();
      // Program 1, byte address = 2 * index
      progTab[0]  = wideInstr(opLbi, 3'd1, 8'h5A);           // r1 = 005A
      progTab[1]  = wideInstr(opLbi, 3'd2, 8'hF3);           // r2 = FFF3
      progTab[2]  = rInstr(fnAdd, 3'd1, 3'd2, 3'd3);
      progTab[3]  = rInstr(fnSub, 3'd1, 3'd2, 3'd4);
      progTab[4]  = rInstr(fnAnd, 3'd1, 3'd2, 3'd5);
      progTab[5]  = rInstr(fnXor, 3'd1, 3'd2, 3'd6);
      progTab[6]  = iInstr(opAddi, 3'd1, 3'd3, 5'h1C);       // -4
      progTab[7]  = iInstr(opAndni, 3'd2, 3'd4, 5'h13);      // Zero-extended, bit 4 set
      progTab[8]  = wideInstr(opLbi, 3'd0, 8'h80);           // r0 is a normal reg
      progTab[9]  = iInstr(opSt, 3'd1, 3'd6, 5'h1E);         // mem[0058] = r6
      progTab[10] = iInstr(opLd, 3'd1, 3'd5, 5'h1E);
      progTab[11] = wideInstr(opBeqz, 3'd1, 8'h02);          // Not taken
      progTab[12] = wideInstr(opLbi, 3'd2, 8'h11);
      progTab[13] = wideInstr(opBnez, 3'd1, 8'h02);          // Taken to 15
      progTab[14] = wideInstr(opLbi, 3'd2, 8'h22);           // Skipped
      progTab[15] = wideInstr(opLbi, 3'd3, 8'h00);
      progTab[16] = wideInstr(opBnez, 3'd3, 8'h02);          // Not taken
      progTab[17] = wideInstr(opBeqz, 3'd3, 8'h02);          // Taken to 19
      progTab[18] = wideInstr(opLbi, 3'd2, 8'h33);           // Skipped
      progTab[19] = jumpInstr(opJal, 11'd4);                 // Call 22, r7 = 0028
      progTab[20] = wideInstr(opLbi, 3'd4, 8'h44);           // Return point
      progTab[21] = jumpInstr(opHalt, 11'd0);
      progTab[22] = iInstr(opAddi, 3'd0, 3'd0, 5'h01);
      progTab[23] = wideInstr(opJr, 3'd7, 8'h00);            // Back to 20
      // Program 2
      progTab[24] = wideInstr(opLbi, 3'd1, 8'h7F);
      progTab[25] = iInstr(opAddi, 3'd1, 3'd2, 5'h0F);
      progTab[26] = instrT'(16'hF8E0);                       // Opcode 11111
      progTab[27] = wideInstr(opLbi, 3'd3, 8'h12);           // Never runs
      progTab[28] = jumpInstr(opHalt, 11'd0);
      // Writes of program 1
      expTab[0]  = expWrite(3'd1, 16'h005A);
      expTab[1]  = expWrite(3'd2, 16'hFFF3);
      expTab[2]  = expWrite(3'd3, 16'h004D);  // 90 + -13
      expTab[3]  = expWrite(3'd4, 16'h0067);  // 90 - -13
      expTab[4]  = expWrite(3'd5, 16'h0052);
      expTab[5]  = expWrite(3'd6, 16'hFFA9);
      expTab[6]  = expWrite(3'd3, 16'h0056);
      expTab[7]  = expWrite(3'd4, 16'hFFE0);  // FFF3 & ~0013
      expTab[8]  = expWrite(3'd0, 16'hFF80);
      expTab[9]  = expWrite(3'd5, 16'hFFA9);  // Stored word comes back
      expTab[10] = expWrite(3'd2, 16'h0011);
      expTab[11] = expWrite(3'd3, 16'h0000);
      expTab[12] = expWrite(3'd7, 16'h0028);  // Link
      expTab[13] = expWrite(3'd0, 16'hFF81);
      expTab[14] = expWrite(3'd4, 16'h0044);
      // Writes of program 2, registers start at zero
      expTab[15] = expWrite(3'd1, 16'h007F);
      expTab[16] = expWrite(3'd2, 16'h008E);
   endtask

   // Reset lasts 10 cycles, or longer when the program needs more load slots
   task automatic loadProgram(input int base, input int len);
      int nCyc;
      int c;
      nCyc = (len > RST_CYCLES) ? len : RST_CYCLES;
      @(posedge clk);
      rst <= 1'b1;
      for (c = 0; c < nCyc; c++) begin
         if (c < len) begin
            progWr   <= 1'b1;
            progAddr <= 16'(2 * c);  // Byte address
            progData <= progTab[base + c];
         end else begin
            progWr <= 1'b0;
         end
         @(posedge clk);
      end
      progWr <= 1'b0;
      rst    <= 1'b0;  // Word 0 runs in the next cycle
   endtask

   task automatic runProgram(input int base, input int len, input logic expErr);
      int idx;
      idx = 0;
      @(negedge clk);
      checkFlag("halt", halt, 1'b0);
      checkFlag("err", err, 1'b0);
      while (!halt) begin
         if (trace.wrEn) begin
            if (idx >= len)
               reportFail($sformatf("unexpected write to r%0d after the last expected one",
                                    trace.wrReg));
            else
               checkTrace(trace, expTab[base + idx], base + idx);
            idx++;
         end
         @(negedge clk);
      end
      if (idx != len)
         reportFail($sformatf("halted after %0d of %0d expected writes", idx, len));
      checkFlag("err", err, expErr);
      repeat (4) begin  // Stopped state must stay quiet
         @(negedge clk);
         checkFlag("trace.wrEn", trace.wrEn, 1'b0);
         checkFlag("halt", halt, 1'b1);
         checkFlag("err", err, expErr);
      end
   endtask

   initial begin
      rst      = 1'b1;
      progWr   = 1'b0;
      progAddr = '0;
      progData = '0;
      fillTables();
      if (P1_LEN > `PROC_IMEM_WORDS || P2_LEN > `PROC_IMEM_WORDS)
         reportFail("a program does not fit in the instruction memory");
      loadProgram(0, P1_LEN);
      runProgram(0, E1_LEN, 1'b0);         // Ends on HALT
      loadProgram(P1_LEN, P2_LEN);
      runProgram(E1_LEN, E2_LEN, 1'b1);    // Ends on the illegal opcode
      $display("No errors");
      $finish;
   end

   initial begin
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("Timeout: the processor did not finish within %0d cycles", WATCH_CYCLES);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

/* sim.f */
+incdir+.
isaPkg.sv
ctrlPkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
control.sv
proc.sv
procTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -f sim.f --top-module procTb --Mdir obj_dir -o procSim \
   || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/procSim 2>&1)
echo "$out"
echo "$out" | grep -qx "No errors" && exit 0 || exit 1
